// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    // ----------------------------------------------------------------------
    // Bus geometry
    // ----------------------------------------------------------------------

    // Byte address and data widths on the AXI side
    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;
    // Byte offset bits inside one bus word
    localparam int LANE_W  = $clog2(STRB_W);
    // Word address as seen by the memory port
    localparam int WORD_AW = ADDR_W - LANE_W;
    localparam int ID_W    = 4;

    // ----------------------------------------------------------------------
    // Memory geometry
    // ----------------------------------------------------------------------

    localparam int MEM_WORDS = 256;
    // Index bits of the physical array
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    // Single-beat write toward the memory
    typedef struct packed {
        logic [WORD_AW-1:0] addr;
        logic [DATA_W-1:0]  data;
        logic [STRB_W-1:0]  strb;
    } comp_wr_t;

endpackage

// ==== rtl/axi_pkg.sv ====
package axi_pkg;

    import mem_pkg::*;

    // ----------------------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------------------

    // AWBURST values, 2'b11 is reserved and treated as INCR
    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10
    } axi_burst_e;

    // BRESP values, EXOKAY is never produced here
    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_SLVERR = 2'b10
    } axi_resp_e;

    // ----------------------------------------------------------------------
    // Channel payloads
    // ----------------------------------------------------------------------

    // Write request context
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [7:0]        len;
        logic [2:0]        size;
        axi_burst_e        burst;
    } axi_aw_t;

    // One write data beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    // One write response
    typedef struct packed {
        logic [ID_W-1:0] id;
        axi_resp_e       resp;
    } axi_b_t;

endpackage

// ==== rtl/skid_buffer.sv ====
module skid_buffer #(
    parameter type T       = logic,
    parameter bit  OUT_REG = 1'b0
) (
    input  logic clk,
    input  logic rst_n,

    // Upstream side
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,

    // Downstream side
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    // Overflow slot, filled when the output stalls with a beat in flight
    logic r_valid;
    T     r_data;

    // Ready toward the source comes straight from a flop
    assign o_ready = !r_valid;

    // Slot takes a beat that arrives while the output is stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (i_valid && o_ready && o_valid && !i_ready) begin
            r_valid <= 1'b1;
        end else if (i_ready) begin
            r_valid <= 1'b0;
        end
    end

    // Capture whenever the slot is free, only kept once r_valid sets
    always_ff @(posedge clk) begin
        if (o_ready) begin
            r_data <= i_data;
        end
    end

    // ----------------------------------------------------------------------
    // Output stage
    // ----------------------------------------------------------------------

    generate
        if (OUT_REG) begin : g_out_reg
            logic out_valid_q;
            T     out_data_q;

            // Load when empty or when the current beat leaves
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    out_valid_q <= 1'b0;
                end else if (!out_valid_q || i_ready) begin
                    out_valid_q <= i_valid || r_valid;
                end
            end

            // Slot content goes first to keep order
            always_ff @(posedge clk) begin
                if (!out_valid_q || i_ready) begin
                    out_data_q <= r_valid ? r_data : i_data;
                end
            end

            assign o_valid = out_valid_q;
            assign o_data  = out_data_q;
        end else begin : g_out_comb
            // Pass-through unless a beat sits in the slot
            assign o_valid = i_valid || r_valid;
            assign o_data  = r_valid ? r_data : i_data;
        end
    endgenerate

endmodule

// ==== rtl/burst_addr_gen.sv ====
module burst_addr_gen import mem_pkg::*, axi_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               i_load,
    input  logic               i_step,
    input  axi_aw_t            i_aw,

    output logic [ADDR_W-1:0]  o_addr,
    output logic [WORD_AW-1:0] o_word_addr,
    output logic               o_last_beat
);

    // Burst state
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        cnt_q;
    logic [7:0]        len_q;
    logic [2:0]        size_q;
    axi_burst_e        burst_q;
    logic              last_q;

    // Next address terms
    logic [ADDR_W-1:0] size_bytes;
    logic [ADDR_W-1:0] align_mask;
    logic [ADDR_W-1:0] incr_addr;
    logic [ADDR_W-1:0] wrap_mask;
    logic [ADDR_W-1:0] addr_nxt;

    // ----------------------------------------------------------------------
    // Address step
    // ----------------------------------------------------------------------

    always_comb begin
        size_bytes = ADDR_W'(1) << size_q;
        align_mask = ~(size_bytes - ADDR_W'(1));
        // Unaligned start snaps to the size boundary after the first beat
        incr_addr  = (addr_q & align_mask) + size_bytes;
        // Wrap window is size times beat count, a power of two for WRAP
        wrap_mask  = ((ADDR_W'(len_q) + ADDR_W'(1)) << size_q) - ADDR_W'(1);
        case (burst_q)
            AXI_BURST_FIXED: addr_nxt = addr_q;
            AXI_BURST_WRAP:  addr_nxt = (addr_q & ~wrap_mask) | (incr_addr & wrap_mask);
            default:         addr_nxt = incr_addr;
        endcase
    end

    // ----------------------------------------------------------------------
    // State update
    // ----------------------------------------------------------------------

    // Load wins over step, so a final beat can hand over to the next burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q  <= '0;
            cnt_q   <= '0;
            len_q   <= '0;
            size_q  <= '0;
            burst_q <= AXI_BURST_FIXED;
            last_q  <= 1'b0;
        end else if (i_load) begin
            addr_q  <= i_aw.addr;
            cnt_q   <= i_aw.len;
            len_q   <= i_aw.len;
            size_q  <= i_aw.size;
            burst_q <= i_aw.burst;
            last_q  <= (i_aw.len == 8'd0);
        end else if (i_step) begin
            addr_q  <= addr_nxt;
            cnt_q   <= cnt_q - 8'd1;
            // Remaining count about to reach zero
            last_q  <= (cnt_q == 8'd1);
        end
    end

    assign o_addr      = addr_q;
    assign o_word_addr = addr_q[ADDR_W-1:LANE_W];
    assign o_last_beat = last_q;

endmodule

// ==== rtl/axi_wr_ctrl.sv ====
module axi_wr_ctrl import mem_pkg::*, axi_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    // Request from the AW buffer
    input  logic     i_aw_valid,
    output logic     o_aw_ready,
    input  axi_aw_t  i_aw,

    // Data beats from the W buffer
    input  logic     i_w_valid,
    output logic     o_w_ready,
    input  axi_w_t   i_w,

    // Responses into the B buffer
    output logic     o_b_valid,
    input  logic     i_b_ready,
    output axi_b_t   o_b,

    // Memory port
    output logic     o_comp_wr_stb,
    output comp_wr_t o_comp_wr,
    input  logic     i_comp_err
);

    typedef enum logic {
        ST_IDLE,
        ST_BURST
    } state_e;

    state_e              state_q;
    logic                aw_fire;
    logic                w_fire;
    logic                final_fire;
    logic                b_room;

    // Context of the active burst
    logic [ID_W-1:0]     txn_id;
    logic [2:0]          txn_size;
    logic [ADDR_W-1:0]   gen_addr;
    logic [WORD_AW-1:0]  gen_word_addr;
    logic                gen_last;

    // Byte lanes covered by the current beat
    logic [STRB_W-1:0]   size_strb;
    logic [LANE_W-1:0]   lane_lo;
    logic [LANE_W-1:0]   lane_base;
    logic [STRB_W-1:0]   lane_mask;

    // Write stage and response stage
    logic                stb_last;
    logic [ID_W-1:0]     stb_id;
    logic                err_q;

    // ----------------------------------------------------------------------
    // Handshakes
    // ----------------------------------------------------------------------

    // Room for one more response, counting those still in the pipe
    assign b_room     = i_b_ready && !stb_last && !o_b_valid;
    // Final beat waits for room so its response can never be dropped
    assign o_w_ready  = (state_q == ST_BURST) && (!gen_last || b_room);
    assign w_fire     = i_w_valid && o_w_ready;
    // Beat count ends the burst, wlast is ignored
    assign final_fire = w_fire && gen_last;
    assign o_aw_ready = b_room && ((state_q == ST_IDLE) || final_fire);
    assign aw_fire    = i_aw_valid && o_aw_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else if (aw_fire) begin
            state_q <= ST_BURST;
        end else if (final_fire) begin
            state_q <= ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            txn_id   <= i_aw.id;
            txn_size <= i_aw.size;
        end
    end

    burst_addr_gen i_addr_gen (
        .clk         (clk          ),
        .rst_n       (rst_n        ),
        .i_load      (aw_fire      ),
        .i_step      (w_fire       ),
        .i_aw        (i_aw         ),
        .o_addr      (gen_addr     ),
        .o_word_addr (gen_word_addr),
        .o_last_beat (gen_last     )
    );

    // ----------------------------------------------------------------------
    // Lane mask for narrow and unaligned beats
    // ----------------------------------------------------------------------

    always_comb begin
        if (txn_size >= 3'(LANE_W)) begin
            size_strb = '1;
            lane_lo   = '1;
        end else begin
            size_strb = STRB_W'((32'd1 << (32'd1 << txn_size)) - 32'd1);
            lane_lo   = LANE_W'((32'd1 << txn_size) - 32'd1);
        end
        // Container of the transfer, trimmed below the start byte
        lane_base = gen_addr[LANE_W-1:0] & ~lane_lo;
        lane_mask = (size_strb << lane_base) & ({STRB_W{1'b1}} << gen_addr[LANE_W-1:0]);
    end

    // ----------------------------------------------------------------------
    // Write stage, memory sees the beat one edge after it is consumed
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_comp_wr_stb <= 1'b0;
            stb_last      <= 1'b0;
        end else begin
            o_comp_wr_stb <= w_fire;
            stb_last      <= final_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (w_fire) begin
            o_comp_wr.addr <= gen_word_addr;
            o_comp_wr.data <= i_w.data;
            o_comp_wr.strb <= i_w.strb & lane_mask;
            stb_id         <= txn_id;
        end
    end

    // ----------------------------------------------------------------------
    // Response stage
    // ----------------------------------------------------------------------

    // Sticky error, restarts with the beat after a final one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q     <= 1'b0;
            o_b_valid <= 1'b0;
        end else begin
            o_b_valid <= stb_last;
            if (stb_last) begin
                err_q <= 1'b0;
            end else if (o_comp_wr_stb && i_comp_err) begin
                err_q <= 1'b1;
            end
        end
    end

    // Final beat error still counts in its own cycle
    always_ff @(posedge clk) begin
        if (stb_last) begin
            o_b.id   <= stb_id;
            o_b.resp <= (err_q || i_comp_err) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        end
    end

endmodule

// ==== rtl/wr_mem.sv ====
module wr_mem import mem_pkg::*; (
    input  logic              clk,

    // Write port, no back-pressure
    input  logic              i_wr_stb,
    input  comp_wr_t          i_wr,
    output logic              o_err,

    // Registered read port
    input  logic              i_rd_en,
    input  logic [MEM_AW-1:0] i_rd_addr,
    output logic [DATA_W-1:0] o_rd_data
);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic              in_range;
    logic [MEM_AW-1:0] wr_idx;

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------

    // Word address above the array is an error, nothing gets written
    assign in_range = (i_wr.addr < WORD_AW'(MEM_WORDS));
    assign wr_idx   = i_wr.addr[MEM_AW-1:0];
    // Answered in the same cycle as the strobe
    assign o_err    = i_wr_stb && !in_range;

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------

    // Byte lanes update one by one under the strobe
    always_ff @(posedge clk) begin
        if (i_wr_stb && in_range) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (i_wr.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= i_wr.data[8*b +: 8];
                end
            end
        end
    end

    // Data is valid the cycle after i_rd_en
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

// ==== rtl/axi_wr_sub_top.sv ====
module axi_wr_sub_top import mem_pkg::*, axi_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // AW channel
    input  logic              i_aw_valid,
    output logic              o_aw_ready,
    input  axi_aw_t           i_aw,

    // W channel
    input  logic              i_w_valid,
    output logic              o_w_ready,
    input  axi_w_t            i_w,

    // B channel
    output logic              o_b_valid,
    input  logic              i_b_ready,
    output axi_b_t            o_b,

    // Memory readback
    input  logic              i_rd_en,
    input  logic [MEM_AW-1:0] i_rd_addr,
    output logic [DATA_W-1:0] o_rd_data
);

    // Buffered request
    logic     aw_valid;
    logic     aw_ready;
    axi_aw_t  aw;
    // Buffered data beat
    logic     w_valid;
    logic     w_ready;
    axi_w_t   w;
    // Response push
    logic     b_valid;
    logic     b_ready;
    axi_b_t   b;
    // Memory port
    logic     comp_wr_stb;
    comp_wr_t comp_wr;
    logic     comp_err;

    // ----------------------------------------------------------------------
    // Channel buffers
    // ----------------------------------------------------------------------

    skid_buffer #(
        .T       (axi_aw_t),
        .OUT_REG (1'b0    )
    ) i_aw_skd (
        .clk     (clk       ),
        .rst_n   (rst_n     ),
        .i_valid (i_aw_valid),
        .o_ready (o_aw_ready),
        .i_data  (i_aw      ),
        .o_valid (aw_valid  ),
        .i_ready (aw_ready  ),
        .o_data  (aw        )
    );

    skid_buffer #(
        .T       (axi_w_t),
        .OUT_REG (1'b0   )
    ) i_w_skd (
        .clk     (clk      ),
        .rst_n   (rst_n    ),
        .i_valid (i_w_valid),
        .o_ready (o_w_ready),
        .i_data  (i_w      ),
        .o_valid (w_valid  ),
        .i_ready (w_ready  ),
        .o_data  (w        )
    );

    // Registered toward the bus
    skid_buffer #(
        .T       (axi_b_t),
        .OUT_REG (1'b1   )
    ) i_b_skd (
        .clk     (clk      ),
        .rst_n   (rst_n    ),
        .i_valid (b_valid  ),
        .o_ready (b_ready  ),
        .i_data  (b        ),
        .o_valid (o_b_valid),
        .i_ready (i_b_ready),
        .o_data  (o_b      )
    );

    // ----------------------------------------------------------------------
    // Controller and memory
    // ----------------------------------------------------------------------

    axi_wr_ctrl i_ctrl (
        .clk           (clk        ),
        .rst_n         (rst_n      ),
        .i_aw_valid    (aw_valid   ),
        .o_aw_ready    (aw_ready   ),
        .i_aw          (aw         ),
        .i_w_valid     (w_valid    ),
        .o_w_ready     (w_ready    ),
        .i_w           (w          ),
        .o_b_valid     (b_valid    ),
        .i_b_ready     (b_ready    ),
        .o_b           (b          ),
        .o_comp_wr_stb (comp_wr_stb),
        .o_comp_wr     (comp_wr    ),
        .i_comp_err    (comp_err   )
    );

    wr_mem i_mem (
        .clk       (clk        ),
        .i_wr_stb  (comp_wr_stb),
        .i_wr      (comp_wr    ),
        .o_err     (comp_err   ),
        .i_rd_en   (i_rd_en    ),
        .i_rd_addr (i_rd_addr  ),
        .o_rd_data (o_rd_data  )
    );

endmodule

// ==== testbench/tb_checker.sv ====
module tb_checker import mem_pkg::*, axi_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // Observed DUT ports
    input  logic              i_aw_valid,
    input  logic              i_aw_ready,
    input  axi_aw_t           i_aw,
    input  logic              i_w_valid,
    input  logic              i_w_ready,
    input  axi_w_t            i_w,
    input  logic              i_b_valid,
    input  logic              i_b_ready,
    input  axi_b_t            i_b,
    input  logic              i_rd_en,
    input  logic [MEM_AW-1:0] i_rd_addr,
    input  logic [DATA_W-1:0] i_rd_data,

    // End of run request and results
    input  logic              i_done,
    output int                o_resp_cnt,
    output int                o_err_cnt
);

    timeunit 1ns;
    timeprecision 1ps;

    // Reference memory and pending traffic
    logic [DATA_W-1:0] model_mem [MEM_WORDS];
    axi_aw_t           aw_q [$];
    axi_w_t            w_q [$];
    axi_b_t            exp_q [$];

    // Burst being replayed on the model
    axi_aw_t           cur;
    logic [ADDR_W-1:0] cur_addr;
    int                beat_idx = 0;
    bit                busy = 1'b0;
    bit                cur_err = 1'b0;

    // Readback one cycle behind i_rd_en
    bit                rd_pend = 1'b0;
    logic [MEM_AW-1:0] rd_pend_addr;

    int aw_cnt    = 0;
    int resp_cnt  = 0;
    int resp_errs = 0;
    int data_errs = 0;
    int misc_errs = 0;

    assign o_resp_cnt = resp_cnt;
    assign o_err_cnt  = resp_errs + data_errs + misc_errs;

    // ----------------------------------------------------------------------
    // Burst address rule
    // ----------------------------------------------------------------------

    function automatic logic [ADDR_W-1:0] next_addr(axi_aw_t a, logic [ADDR_W-1:0] addr);
        int nbytes;
        int stepped;
        int span;
        int base;
        nbytes  = 1 << a.size;
        // Following size boundary
        stepped = (int'(addr) / nbytes) * nbytes + nbytes;
        // Wrap window is size times beat count
        span    = nbytes * (int'(a.len) + 1);
        base    = (int'(addr) / span) * span;
        case (a.burst)
            AXI_BURST_FIXED: return addr;
            AXI_BURST_WRAP:  return ADDR_W'(base + (stepped - base) % span);
            default:         return ADDR_W'(stepped);
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Model update
    // ----------------------------------------------------------------------

    // Pair W beats with requests in order, W may arrive before its AW
    task automatic apply_beats();
        axi_w_t beat;
        axi_b_t exp;
        int     widx;
        while (w_q.size() > 0 && (busy || aw_q.size() > 0)) begin
            if (!busy) begin
                cur      = aw_q.pop_front();
                cur_addr = cur.addr;
                beat_idx = 0;
                cur_err  = 1'b0;
                busy     = 1'b1;
            end
            beat = w_q.pop_front();
            widx = int'(cur_addr >> LANE_W);
            // Out of range beats flag the burst and leave memory alone
            if (widx >= MEM_WORDS) begin
                cur_err = 1'b1;
            end else begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (beat.strb[b]) begin
                        model_mem[widx][8*b +: 8] = beat.data[8*b +: 8];
                    end
                end
            end
            if (beat_idx == int'(cur.len)) begin
                exp.id   = cur.id;
                exp.resp = cur_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
                exp_q.push_back(exp);
                busy = 1'b0;
            end else begin
                cur_addr = next_addr(cur, cur_addr);
                beat_idx++;
            end
        end
    endtask

    // Responses must follow request order
    task automatic check_resp(axi_b_t got);
        axi_b_t exp;
        if (exp_q.size() == 0) begin
            $display("ERROR: response with id %0d arrived with no burst completed", got.id);
            misc_errs++;
        end else begin
            exp = exp_q.pop_front();
            if (got.id !== exp.id) begin
                $display("CHECK FAILED: response_id expected %0d actual %0d", exp.id, got.id);
                resp_errs++;
            end
            if (got.resp !== exp.resp) begin
                $display("CHECK FAILED: response_code id %0d expected %0h actual %0h",
                         exp.id, exp.resp, got.resp);
                resp_errs++;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Port monitor
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        if (rst_n) begin
            if (i_aw_valid && i_aw_ready) begin
                aw_q.push_back(i_aw);
                aw_cnt++;
            end
            if (i_w_valid && i_w_ready) begin
                w_q.push_back(i_w);
            end
            apply_beats();
            if (i_b_valid && i_b_ready) begin
                resp_cnt++;
                check_resp(i_b);
            end
            // Data of the previous read request is on the port now
            if (rd_pend && (i_rd_data !== model_mem[rd_pend_addr])) begin
                $display("CHECK FAILED: readback_word[%0d] expected %h actual %h",
                         rd_pend_addr, model_mem[rd_pend_addr], i_rd_data);
                data_errs++;
            end
            rd_pend      = i_rd_en;
            rd_pend_addr = i_rd_addr;
        end
    end

    // End of run bookkeeping and closing line
    always @(posedge i_done) begin
        if (resp_cnt != aw_cnt) begin
            $display("CHECK FAILED: response_count expected %0d actual %0d", aw_cnt, resp_cnt);
            misc_errs++;
        end
        if (busy || exp_q.size() != 0 || aw_q.size() != 0 || w_q.size() != 0) begin
            $display("ERROR: bursts left unfinished at the end of the run");
            misc_errs++;
        end
        $display("Errors: response %0d, readback %0d, other %0d (%0d responses, %0d requests)",
                 resp_errs, data_errs, misc_errs, resp_cnt, aw_cnt);
    end

endmodule

// ==== testbench/tb_top.sv ====
module tb_top import mem_pkg::*, axi_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS        = 8;
    localparam int SEED          = 24268;
    localparam int NUM_RAND      = 300;
    // Burst 0 fills the whole memory first
    localparam int NUM_BURSTS    = NUM_RAND + 1;
    localparam int CYC_PER_BURST = 40;
    // Fill, readback and some slack on top of the random bursts
    localparam int TIMEOUT_NS    = (NUM_RAND * CYC_PER_BURST + 2 * MEM_WORDS + 1000) * CLK_NS;

    logic              clk;
    logic              rst_n;
    logic              aw_valid;
    logic              aw_ready;
    axi_aw_t           aw;
    logic              w_valid;
    logic              w_ready;
    axi_w_t            w;
    logic              b_valid;
    logic              b_ready;
    axi_b_t            b;
    logic              rd_en;
    logic [MEM_AW-1:0] rd_addr;
    logic [DATA_W-1:0] rd_data;
    logic              done;
    int                resp_cnt;
    int                err_cnt;

    axi_aw_t           bursts [NUM_BURSTS];

    axi_wr_sub_top i_dut (
        .clk        (clk     ),
        .rst_n      (rst_n   ),
        .i_aw_valid (aw_valid),
        .o_aw_ready (aw_ready),
        .i_aw       (aw      ),
        .i_w_valid  (w_valid ),
        .o_w_ready  (w_ready ),
        .i_w        (w       ),
        .o_b_valid  (b_valid ),
        .i_b_ready  (b_ready ),
        .o_b        (b       ),
        .i_rd_en    (rd_en   ),
        .i_rd_addr  (rd_addr ),
        .o_rd_data  (rd_data )
    );

    tb_checker i_chk (
        .clk        (clk     ),
        .rst_n      (rst_n   ),
        .i_aw_valid (aw_valid),
        .i_aw_ready (aw_ready),
        .i_aw       (aw      ),
        .i_w_valid  (w_valid ),
        .i_w_ready  (w_ready ),
        .i_w        (w       ),
        .i_b_valid  (b_valid ),
        .i_b_ready  (b_ready ),
        .i_b        (b       ),
        .i_rd_en    (rd_en   ),
        .i_rd_addr  (rd_addr ),
        .i_rd_data  (rd_data ),
        .i_done     (done    ),
        .o_resp_cnt (resp_cnt),
        .o_err_cnt  (err_cnt )
    );

    // ----------------------------------------------------------------------
    // Address and lane helpers
    // ----------------------------------------------------------------------

    function automatic logic [ADDR_W-1:0] next_addr(axi_aw_t a, logic [ADDR_W-1:0] addr);
        int nbytes;
        int stepped;
        int span;
        int base;
        nbytes  = 1 << a.size;
        stepped = (int'(addr) / nbytes) * nbytes + nbytes;
        span    = nbytes * (int'(a.len) + 1);
        base    = (int'(addr) / span) * span;
        case (a.burst)
            AXI_BURST_FIXED: return addr;
            AXI_BURST_WRAP:  return ADDR_W'(base + (stepped - base) % span);
            default:         return ADDR_W'(stepped);
        endcase
    endfunction

    // Lanes from the start byte up to the end of the size container
    function automatic logic [STRB_W-1:0] addr_lanes(logic [ADDR_W-1:0] addr, logic [2:0] size);
        int                lo;
        int                hi;
        logic [STRB_W-1:0] m;
        lo = int'(addr) % STRB_W;
        hi = ((int'(addr) >> size) << size) % STRB_W + (1 << size) - 1;
        for (int n = 0; n < STRB_W; n++) begin
            m[n] = (n >= lo) && (n <= hi);
        end
        return m;
    endfunction

    task automatic make_bursts();
        axi_aw_t a;
        for (int k = 0; k < NUM_BURSTS; k++) begin
            a.id    = ID_W'($urandom);
            a.size  = 3'($urandom_range(2, 0));
            a.burst = axi_burst_e'(2'($urandom_range(2, 0)));
            // WRAP only takes 2, 4, 8 or 16 beats
            if (a.burst == AXI_BURST_WRAP) begin
                a.len = 8'((2 << $urandom_range(3, 0)) - 1);
            end else begin
                a.len = 8'($urandom_range(15, 0));
            end
            // About one in ten starts beyond the memory
            if ($urandom_range(9, 0) == 0) begin
                a.addr = ADDR_W'($urandom_range(32'hf000, MEM_WORDS * STRB_W));
            end else begin
                a.addr = ADDR_W'($urandom_range(MEM_WORDS * STRB_W - 1, 0));
            end
            if (a.burst == AXI_BURST_WRAP) begin
                a.addr = a.addr & ~((ADDR_W'(1) << a.size) - ADDR_W'(1));
            end
            bursts[k] = a;
        end
        bursts[0] = '{addr: '0, id: '0, len: 8'd255, size: 3'd2, burst: AXI_BURST_INCR};
    endtask

    // ----------------------------------------------------------------------
    // Clock, reset and main sequence
    // ----------------------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        void'($urandom(SEED));
        rst_n    = 1'b0;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b0;
        rd_en    = 1'b0;
        rd_addr  = '0;
        done     = 1'b0;
        make_bursts();
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        wait (resp_cnt == NUM_BURSTS);
        @(posedge clk);
        #1;
        // Read every word back through the registered port
        for (int i = 0; i < MEM_WORDS; i++) begin
            rd_en   = 1'b1;
            rd_addr = MEM_AW'(i);
            @(posedge clk);
            #1;
        end
        rd_en = 1'b0;
        repeat (2) @(posedge clk);
        #1 done = 1'b1;
        @(posedge clk);
        #1;
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // Channel drivers
    // ----------------------------------------------------------------------

    initial begin : aw_driver
        logic taken;
        wait (rst_n === 1'b1);
        for (int k = 0; k < NUM_BURSTS; k++) begin
            if ($urandom_range(3, 0) == 0) begin
                repeat ($urandom_range(2, 1)) begin
                    @(posedge clk);
                    #1;
                end
            end
            aw_valid = 1'b1;
            aw       = bursts[k];
            // Ready at the falling edge decides the next rising one
            do begin
                @(negedge clk);
                taken = aw_ready;
                @(posedge clk);
                #1;
            end while (!taken);
            aw_valid = 1'b0;
        end
    end

    initial begin : w_driver
        logic              taken;
        axi_aw_t           a;
        logic [ADDR_W-1:0] addr;
        wait (rst_n === 1'b1);
        for (int k = 0; k < NUM_BURSTS; k++) begin
            a    = bursts[k];
            addr = a.addr;
            for (int n = 0; n <= int'(a.len); n++) begin
                // Random gaps in the W stream
                if ($urandom_range(3, 0) == 0) begin
                    repeat ($urandom_range(3, 1)) begin
                        @(posedge clk);
                        #1;
                    end
                end
                w_valid = 1'b1;
                w.last  = (n == int'(a.len));
                if (k == 0) begin
                    w.data = {8'ha5, 8'(n), ~8'(n), 8'h5a ^ 8'(n)};
                    w.strb = '1;
                end else begin
                    w.data = $urandom;
                    w.strb = STRB_W'($urandom) & addr_lanes(addr, a.size);
                end
                do begin
                    @(negedge clk);
                    taken = w_ready;
                    @(posedge clk);
                    #1;
                end while (!taken);
                w_valid = 1'b0;
                addr    = next_addr(a, addr);
            end
        end
    end

    // Mostly ready, with rare long stalls on B
    initial begin : b_ready_driver
        int hold;
        wait (rst_n === 1'b1);
        forever begin
            if ($urandom_range(49, 0) == 0) begin
                hold    = $urandom_range(40, 10);
                b_ready = 1'b0;
            end else begin
                hold    = 1;
                b_ready = ($urandom_range(3, 0) != 0);
            end
            repeat (hold) begin
                @(posedge clk);
                #1;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns, %0d responses seen",
                 TIMEOUT_NS, resp_cnt);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/mem_pkg.sv
rtl/axi_pkg.sv
rtl/skid_buffer.sv
rtl/burst_addr_gen.sv
rtl/axi_wr_ctrl.sv
rtl/wr_mem.sv
rtl/axi_wr_sub_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== Makefile ====
# Verilator build and run for the AXI write subordinate

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM_BIN   ?= $(BUILD_DIR)/V$(TOP)
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

# Output goes to the terminal and is searched for the pass line
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
